// ==== dft_cfg_pkg.sv ====
// Width typedefs, complex sample type, twiddle constants and the phase FSM enum
package dft_cfg_pkg;

	// ----------------------------------------
	// Data widths
	// ----------------------------------------
	// One signed real or imaginary component
	typedef logic signed [15:0] sample_t;

	// Complex sample, real part in the upper half
	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// Memory address, one spare bit above POINTS = 32
	typedef logic [5:0] addr_t;
	typedef logic [2:0] stage_t;
	typedef logic [4:0] twidx_t;

	// ----------------------------------------
	// Twiddle format
	// ----------------------------------------
	localparam int TW_FRAC = 14;
	localparam int TW_W = 16;
	// Q1.14 plus sign, so +1.0 is representable
	typedef logic signed [TW_W-1:0] tw_t;

	// Top level phases
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SINK,
		PH_COMPUTE,
		PH_DRAIN,
		PH_SOURCE
	} phase_e;

endpackage

// ==== dft_stream_pkg.sv ====
// Packed structs for stream beats and butterfly requests and results
package dft_stream_pkg;

	import dft_cfg_pkg::*;

	// ----------------------------------------
	// Stream beat, input and output side
	// ----------------------------------------
	typedef struct packed {
		logic  valid;
		logic  sop;
		logic  eop;
		cplx_t data;
	} beat_t;

	// ----------------------------------------
	// Butterfly interface
	// ----------------------------------------
	// Operand pair with its twiddle and home addresses
	typedef struct packed {
		logic   valid;
		cplx_t  a;
		cplx_t  b;
		twidx_t twidx;
		addr_t  addr_a;
		addr_t  addr_b;
	} bfly_req_t;

	// Sum goes back to addr_a, twiddled difference to addr_b
	typedef struct packed {
		logic  valid;
		cplx_t sum;
		cplx_t diff;
		addr_t addr_a;
		addr_t addr_b;
	} bfly_res_t;

endpackage

// ==== dft_sample_mem.sv ====
// Complex sample memory, two write ports and two registered read ports
`timescale 1ns/10ps

module dft_sample_mem import dft_cfg_pkg::*;
#(
	parameter int POINTS = 16
)
(
	input  logic  clk,
	input  logic  we_a,
	input  logic  we_b,
	input  addr_t wa,
	input  addr_t wb,
	input  cplx_t wd_a,
	input  cplx_t wd_b,
	input  addr_t ra,
	input  addr_t rb,
	output cplx_t rd_a,
	output cplx_t rd_b
);

	localparam int LOG2_POINTS = $clog2(POINTS);

	// One word per point
	cplx_t mem [POINTS];

	// ----------------------------------------
	// Write ports
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (we_a)
			mem[wa[LOG2_POINTS-1:0]] <= wd_a;
		if (we_b)
			mem[wb[LOG2_POINTS-1:0]] <= wd_b;
	end

	// Registered reads return data one cycle after the address
	always_ff @(posedge clk)
	begin
		rd_a <= mem[ra[LOG2_POINTS-1:0]];
		rd_b <= mem[rb[LOG2_POINTS-1:0]];
	end

	// Both butterfly outputs land on distinct words
	a_no_write_clash: assert property (@(posedge clk) (we_a && we_b) |-> (wa != wb));

endmodule

// ==== dft_addr_gen.sv ====
// Stage and butterfly counters, pair addressing, twiddle index and request assembly
`timescale 1ns/10ps

module dft_addr_gen import dft_cfg_pkg::*, dft_stream_pkg::*;
#(
	parameter int POINTS = 16
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start_stage,
	output addr_t     ra,
	output addr_t     rb,
	input  cplx_t     rd_a,
	input  cplx_t     rd_b,
	output bfly_req_t req,
	output logic      issue_done,
	output logic      last_stage
);

	localparam int LOG2_POINTS = $clog2(POINTS);
	localparam int HALF_PTS = POINTS / 2;

	logic   issuing;
	stage_t stage;
	addr_t  bcnt;
	addr_t  half;
	addr_t  offset;
	addr_t  pair_lo;
	twidx_t tw;

	// Pipeline copy, lines up with the memory read data
	logic   req_valid;
	addr_t  q_addr_a;
	addr_t  q_addr_b;
	twidx_t q_twidx;

	// ----------------------------------------
	// Pair addressing for DIF stage s
	// ----------------------------------------
	always_comb
	begin
		// Half span is POINTS >> (s + 1)
		half = addr_t'(HALF_PTS) >> stage;
		// Low bits pick the offset inside the group
		offset = bcnt & (half - addr_t'(1));
		// Group bits moved up by one to skip the upper halves
		pair_lo = ((bcnt & ~(half - addr_t'(1))) << 1) | offset;
		ra = pair_lo;
		rb = pair_lo + half;
		tw = twidx_t'(offset << stage);
	end

	// ----------------------------------------
	// Stage and butterfly counters
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			issuing <= 1'b0;
			stage <= '0;
			bcnt <= '0;
			issue_done <= 1'b0;
			last_stage <= 1'b0;
			req_valid <= 1'b0;
		end
		else
		begin
			issue_done <= 1'b0;
			req_valid <= issuing;
			if (start_stage)
			begin
				issuing <= 1'b1;
				bcnt <= '0;
				last_stage <= 1'b0;
			end
			else if (issuing)
			begin
				bcnt <= bcnt + addr_t'(1);
				if (bcnt == addr_t'(HALF_PTS - 1))
				begin
					issuing <= 1'b0;
					issue_done <= 1'b1;
					// Wrap so the next frame begins at stage 0
					if (stage == stage_t'(LOG2_POINTS - 1))
					begin
						stage <= '0;
						last_stage <= 1'b1;
					end
					else
						stage <= stage + stage_t'(1);
				end
			end
		end
	end

	// Addresses and twiddle ride one cycle behind
	always_ff @(posedge clk)
	begin
		q_addr_a <= ra;
		q_addr_b <= rb;
		q_twidx <= tw;
	end

	// Request formed from the returning read data
	assign req = '{valid: req_valid, a: rd_a, b: rd_b, twidx: q_twidx,
		addr_a: q_addr_a, addr_b: q_addr_b};

	a_pair_distinct: assert property (@(posedge clk) disable iff (!rst_n)
		issuing |-> (ra != rb));
	// Next stage only after the previous one stopped issuing
	a_start_when_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		start_stage |-> (!issuing && !req_valid));

endmodule

// ==== dft_butterfly.sv ====
// Two-stage radix-2 DIF butterfly with elaborated twiddle ROM and halving
`timescale 1ns/10ps

module dft_butterfly import dft_cfg_pkg::*, dft_stream_pkg::*;
#(
	parameter int POINTS = 16
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  bfly_req_t req,
	output bfly_res_t res
);

	localparam int LOG2_POINTS = $clog2(POINTS);
	localparam int ROM_N = POINTS / 2;
	localparam real PI = 3.14159265358979323846;
	localparam real TW_ONE = 2.0 ** TW_FRAC;

	// ----------------------------------------
	// Twiddle ROM, exp(-j 2 pi k / POINTS)
	// ----------------------------------------
	tw_t rom_re [ROM_N];
	tw_t rom_im [ROM_N];

	for (genvar k = 0; k < ROM_N; k++)
	begin : g_rom
		localparam real ANG = 2.0 * PI * k / POINTS;
		assign rom_re[k] = tw_t'(int'($cos(ANG) * TW_ONE));
		assign rom_im[k] = tw_t'(int'(-$sin(ANG) * TW_ONE));
	end

	// (x +/- y) / 2 with one guard bit, low bit dropped
	function automatic sample_t half_sum(input sample_t x, input sample_t y, input logic sub);
		logic signed [16:0] xe;
		logic signed [16:0] ye;
		logic signed [16:0] r;
		xe = {x[15], x};
		ye = {y[15], y};
		r = sub ? (xe - ye) : (xe + ye);
		return r[16:1];
	endfunction

	// ----------------------------------------
	// Stage 1, halved sum and difference
	// ----------------------------------------
	bfly_res_t s1;
	twidx_t    s1_twidx;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			s1.valid <= 1'b0;
		else
			s1.valid <= req.valid;
	end

	always_ff @(posedge clk)
	begin
		s1.sum.re <= half_sum(req.a.re, req.b.re, 1'b0);
		s1.sum.im <= half_sum(req.a.im, req.b.im, 1'b0);
		s1.diff.re <= half_sum(req.a.re, req.b.re, 1'b1);
		s1.diff.im <= half_sum(req.a.im, req.b.im, 1'b1);
		s1.addr_a <= req.addr_a;
		s1.addr_b <= req.addr_b;
		s1_twidx <= req.twidx;
	end

	// ----------------------------------------
	// Stage 2, complex twiddle multiply
	// ----------------------------------------
	sample_t            d_re;
	sample_t            d_im;
	tw_t                w_re;
	tw_t                w_im;
	logic signed [31:0] p_rr;
	logic signed [31:0] p_ii;
	logic signed [31:0] p_ri;
	logic signed [31:0] p_ir;
	logic signed [32:0] acc_re;
	logic signed [32:0] acc_im;
	cplx_t              prod;

	always_comb
	begin
		d_re = s1.diff.re;
		d_im = s1.diff.im;
		w_re = rom_re[s1_twidx[LOG2_POINTS-2:0]];
		w_im = rom_im[s1_twidx[LOG2_POINTS-2:0]];
		p_rr = d_re * w_re;
		p_ii = d_im * w_im;
		p_ri = d_re * w_im;
		p_ir = d_im * w_re;
		acc_re = 33'(p_rr) - 33'(p_ii);
		acc_im = 33'(p_ri) + 33'(p_ir);
		// Drop the fraction bits, plain truncation
		prod.re = acc_re[TW_FRAC+15:TW_FRAC];
		prod.im = acc_im[TW_FRAC+15:TW_FRAC];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			res.valid <= 1'b0;
		else
			res.valid <= s1.valid;
	end

	always_ff @(posedge clk)
	begin
		res.sum <= s1.sum;
		// W^0 is exactly one, skip the lossy multiply
		res.diff <= (s1_twidx == '0) ? s1.diff : prod;
		res.addr_a <= s1.addr_a;
		res.addr_b <= s1.addr_b;
	end

endmodule

// ==== dft_unload.sv ====
// Bit-reversed readout counter and output stream framing
`timescale 1ns/10ps

module dft_unload import dft_cfg_pkg::*, dft_stream_pkg::*;
#(
	parameter int POINTS = 16
)
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start,
	output addr_t ra,
	input  cplx_t rd,
	output beat_t out_beat,
	output logic  done
);

	localparam int LOG2_POINTS = $clog2(POINTS);

	logic  running;
	addr_t cnt;
	logic  beat_valid;
	logic  beat_sop;
	logic  beat_eop;

	// Mirror the low LOG2_POINTS bits
	function automatic addr_t bit_rev(input addr_t v);
		addr_t r;
		r = '0;
		for (int i = 0; i < LOG2_POINTS; i++)
			r[i] = v[LOG2_POINTS-1-i];
		return r;
	endfunction

	// ----------------------------------------
	// Bin counter and framing flags
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			cnt <= '0;
			beat_valid <= 1'b0;
			beat_sop <= 1'b0;
			beat_eop <= 1'b0;
		end
		else
		begin
			// Flags trail the address by the memory read cycle
			beat_valid <= running;
			beat_sop <= running && (cnt == '0);
			beat_eop <= running && (cnt == addr_t'(POINTS - 1));
			if (start)
			begin
				running <= 1'b1;
				cnt <= '0;
			end
			else if (running)
			begin
				cnt <= cnt + addr_t'(1);
				if (cnt == addr_t'(POINTS - 1))
					running <= 1'b0;
			end
		end
	end

	// DIF leaves bins bit-reversed in memory
	assign ra = bit_rev(cnt);
	assign out_beat = '{valid: beat_valid, sop: beat_sop, eop: beat_eop, data: rd};
	assign done = beat_valid && beat_eop;

	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (!running && !beat_valid));

endmodule

// ==== dft_mem_top.sv ====
// Top level with phase FSM, sink write path, memory port muxing and block instances
`timescale 1ns/10ps

module dft_mem_top import dft_cfg_pkg::*, dft_stream_pkg::*;
#(
	parameter int POINTS = 16
)
(
	input  logic  clk,
	input  logic  rst_n,
	input  beat_t in_beat,
	output beat_t out_beat,
	output logic  busy,
	output logic  overflow
);

	phase_e    phase;
	addr_t     wcnt;
	logic      in_sop_ok;
	logic      in_data_ok;
	logic      in_reject;
	logic      sink_phase;
	logic      start_stage;
	logic      start_unload;
	logic      issue_done;
	logic      last_stage;
	logic      unl_done;
	logic      we_a;
	logic      we_b;
	addr_t     wa;
	addr_t     wb;
	cplx_t     wd_a;
	cplx_t     wd_b;
	addr_t     mem_ra;
	addr_t     gen_ra;
	addr_t     gen_rb;
	addr_t     unl_ra;
	cplx_t     rd_a;
	cplx_t     rd_b;
	bfly_req_t req;
	bfly_res_t res;

	// ----------------------------------------
	// Input acceptance
	// ----------------------------------------
	// The sop beat itself carries sample 0
	assign in_sop_ok = in_beat.valid && in_beat.sop && (phase == PH_IDLE);
	assign in_data_ok = in_beat.valid && !in_beat.sop && (phase == PH_SINK);
	// Busy engine drops the beat, stray sop inside a frame too
	assign in_reject = in_beat.valid &&
		((phase == PH_SINK) ? in_beat.sop : (phase != PH_IDLE));

	// ----------------------------------------
	// Phase FSM
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase <= PH_IDLE;
			wcnt <= '0;
			start_stage <= 1'b0;
			start_unload <= 1'b0;
			overflow <= 1'b0;
		end
		else
		begin
			start_stage <= 1'b0;
			start_unload <= 1'b0;
			overflow <= in_reject;
			case (phase)
				PH_IDLE:
					if (in_sop_ok)
					begin
						wcnt <= addr_t'(1);
						phase <= PH_SINK;
					end
				PH_SINK:
					if (in_data_ok)
					begin
						wcnt <= wcnt + addr_t'(1);
						if (wcnt == addr_t'(POINTS - 1))
						begin
							start_stage <= 1'b1;
							phase <= PH_COMPUTE;
						end
					end
				PH_COMPUTE:
					if (issue_done)
						phase <= PH_DRAIN;
				PH_DRAIN:
					// Registered valid, so low here means a quiet cycle
					if (!res.valid)
					begin
						if (last_stage)
						begin
							start_unload <= 1'b1;
							phase <= PH_SOURCE;
						end
						else
						begin
							start_stage <= 1'b1;
							phase <= PH_COMPUTE;
						end
					end
				PH_SOURCE:
					if (unl_done)
						phase <= PH_IDLE;
				default:
					phase <= PH_IDLE;
			endcase
		end
	end

	assign busy = (phase != PH_IDLE);

	// ----------------------------------------
	// Memory port muxing
	// ----------------------------------------
	assign sink_phase = (phase == PH_IDLE) || (phase == PH_SINK);

	always_comb
	begin
		if (sink_phase)
		begin
			we_a = in_sop_ok || in_data_ok;
			wa = in_sop_ok ? addr_t'(0) : wcnt;
			wd_a = in_beat.data;
			we_b = 1'b0;
		end
		else
		begin
			// In-place write back of both butterfly outputs
			we_a = res.valid;
			wa = res.addr_a;
			wd_a = res.sum;
			we_b = res.valid;
		end
	end

	assign wb = res.addr_b;
	assign wd_b = res.diff;
	assign mem_ra = (phase == PH_SOURCE) ? unl_ra : gen_ra;

	dft_sample_mem #(.POINTS(POINTS)) u_mem (
		.clk  (clk),
		.we_a (we_a),
		.we_b (we_b),
		.wa   (wa),
		.wb   (wb),
		.wd_a (wd_a),
		.wd_b (wd_b),
		.ra   (mem_ra),
		.rb   (gen_rb),
		.rd_a (rd_a),
		.rd_b (rd_b)
	);

	// Decode
	dft_addr_gen #(.POINTS(POINTS)) u_addr_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.start_stage (start_stage),
		.ra          (gen_ra),
		.rb          (gen_rb),
		.rd_a        (rd_a),
		.rd_b        (rd_b),
		.req         (req),
		.issue_done  (issue_done),
		.last_stage  (last_stage)
	);

	// Execute
	dft_butterfly #(.POINTS(POINTS)) u_butterfly (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.res   (res)
	);

	// Result
	dft_unload #(.POINTS(POINTS)) u_unload (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start_unload),
		.ra       (unl_ra),
		.rd       (rd_a),
		.out_beat (out_beat),
		.done     (unl_done)
	);

	// No butterfly write may land while results stream out
	a_quiet_source: assert property (@(posedge clk) disable iff (!rst_n)
		(phase == PH_SOURCE) |-> (!res.valid && !req.valid));

endmodule

// ==== tb_dft_mem_top.sv ====
// DFT engine testbench with clock, reset, frame stimulus and concurrent checking assertions
`timescale 1ns/10ps

module tb_dft_mem_top
	import dft_cfg_pkg::*, dft_stream_pkg::*;
();

	localparam int POINTS = 16;
	localparam int IDX_W = $clog2(POINTS);
	localparam int PAT_IMPULSE = 0;
	localparam int PAT_CONST = 1;
	localparam int PAT_ALT = 2;
	localparam int WAIT_LIMIT = 2000;
	localparam int GOOD_FRAMES = 5;

	logic   clk;
	logic   rst_n;
	beat_t  in_beat;
	beat_t  out_beat;
	logic   busy;
	logic   overflow;
	integer seed;

	// Expected result of the frame in flight in natural bin order
	cplx_t exp_bin [POINTS];
	cplx_t exp_now;
	int    out_idx;
	int    frames_out;
	logic  expect_drop;
	logic  exp_ovf;

	dft_mem_top #(.POINTS(POINTS)) u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_beat  (in_beat),
		.out_beat (out_beat),
		.busy     (busy),
		.overflow (overflow)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	// ----------------------------------------
	// Output bin tracking
	// ----------------------------------------
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_idx <= 0;
			frames_out <= 0;
			exp_ovf <= 1'b0;
		end
		else
		begin
			// Rejected beat shows up as a strobe one cycle later
			exp_ovf <= in_beat.valid && expect_drop;
			if (out_beat.valid)
			begin
				out_idx <= out_beat.eop ? 0 : out_idx + 1;
				if (out_beat.sop)
					frames_out <= frames_out + 1;
			end
		end
	end

	assign exp_now = exp_bin[out_idx[IDX_W-1:0]];

	// ----------------------------------------
	// Checking assertions
	// ----------------------------------------
	a_bin_data: assert property (@(posedge clk) disable iff (!rst_n)
		out_beat.valid |-> (out_beat.data == exp_now))
		else abort_run($sformatf("Error at %0t: out_beat.data bin %0d got %h expected %h",
			$time, $sampled(out_idx), $sampled(out_beat.data), $sampled(exp_now)));
	a_sop_first: assert property (@(posedge clk) disable iff (!rst_n)
		out_beat.valid |-> (out_beat.sop == (out_idx == 0)))
		else abort_run($sformatf("Error at %0t: out_beat.sop got %b expected %b", $time,
			$sampled(out_beat.sop), $sampled(out_idx == 0)));
	a_eop_last: assert property (@(posedge clk) disable iff (!rst_n)
		out_beat.valid |-> (out_beat.eop == (out_idx == POINTS - 1)))
		else abort_run($sformatf("Error at %0t: out_beat.eop got %b expected %b", $time,
			$sampled(out_beat.eop), $sampled(out_idx == POINTS - 1)));
	a_no_stray_flags: assert property (@(posedge clk) disable iff (!rst_n)
		!out_beat.valid |-> (!out_beat.sop && !out_beat.eop))
		else abort_run("Output sop or eop seen on a beat without valid");
	// Frame beats come back to back
	a_no_gap: assert property (@(posedge clk) disable iff (!rst_n)
		(out_beat.valid && !out_beat.eop) |=> out_beat.valid)
		else abort_run($sformatf("Error at %0t: out_beat.valid got 0 expected 1", $time));
	a_out_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		out_beat.valid |-> busy)
		else abort_run("Output beat appeared while the engine was idle");
	// Accepted sop in idle raises busy on the next cycle
	a_busy_set: assert property (@(posedge clk) disable iff (!rst_n)
		(!busy && in_beat.valid && in_beat.sop) |=> busy)
		else abort_run($sformatf("Error at %0t: busy got 0 expected 1", $time));
	a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
		(!busy && !(in_beat.valid && in_beat.sop)) |=> !busy)
		else abort_run($sformatf("Error at %0t: busy got 1 expected 0", $time));
	a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && !(out_beat.valid && out_beat.eop)) |=> busy)
		else abort_run($sformatf("Error at %0t: busy got 0 expected 1", $time));
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		(out_beat.valid && out_beat.eop) |=> !busy)
		else abort_run($sformatf("Error at %0t: busy got 1 expected 0", $time));
	a_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		overflow == exp_ovf)
		else abort_run($sformatf("Error at %0t: overflow got %b expected %b", $time,
			$sampled(overflow), $sampled(exp_ovf)));

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	function automatic sample_t sample_of(input int pat, input int n, input sample_t amp);
		if (pat == PAT_IMPULSE)
			return (n == 0) ? amp : sample_t'(0);
		else if (pat == PAT_CONST)
			return amp;
		else
			return n[0] ? -amp : amp;
	endfunction

	// Bins from the closed-form DFT of each pattern, scaled by 1/POINTS
	task automatic load_expected(input int pat, input sample_t amp);
		for (int k = 0; k < POINTS; k++)
		begin
			exp_bin[k].im = '0;
			if (pat == PAT_IMPULSE)
				exp_bin[k].re = sample_t'(amp / POINTS);
			else if (pat == PAT_CONST)
				exp_bin[k].re = (k == 0) ? amp : sample_t'(0);
			else
				exp_bin[k].re = (k == POINTS / 2) ? amp : sample_t'(0);
		end
	endtask

	task automatic drive_frame(input int pat, input sample_t amp, input logic gaps);
		int gap;
		for (int n = 0; n < POINTS; n++)
		begin
			gap = gaps ? ($random(seed) & 3) : 0;
			in_beat.valid = 1'b0;
			repeat (gap) step();
			in_beat.valid = 1'b1;
			in_beat.sop = (n == 0);
			in_beat.eop = (n == POINTS - 1);
			in_beat.data.re = sample_of(pat, n, amp);
			in_beat.data.im = '0;
			step();
		end
		in_beat = '0;
	endtask

	task automatic wait_for_sop();
		int n;
		n = 0;
		while (!(out_beat.valid && out_beat.sop) && n < WAIT_LIMIT)
		begin
			step();
			n++;
		end
		if (n >= WAIT_LIMIT)
			abort_run("Timed out waiting for the output sop");
	endtask

	task automatic wait_for_idle();
		int n;
		n = 0;
		while (busy && n < WAIT_LIMIT)
		begin
			step();
			n++;
		end
		if (n >= WAIT_LIMIT)
			abort_run("Timed out waiting for busy to fall");
	endtask

	task automatic run_frame(input int pat, input sample_t amp);
		load_expected(pat, amp);
		drive_frame(pat, amp, 1'b1);
		wait_for_sop();
		wait_for_idle();
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		seed = 32'h8376c9d2;
		rst_n = 1'b0;
		in_beat = '0;
		expect_drop = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		step();
		run_frame(PAT_IMPULSE, 16'sd4096);
		run_frame(PAT_CONST, 16'sd1600);
		run_frame(PAT_ALT, 16'sd8000);
		// Intruding frame right behind a good one is dropped whole
		load_expected(PAT_CONST, 16'sd3200);
		drive_frame(PAT_CONST, 16'sd3200, 1'b1);
		expect_drop = 1'b1;
		drive_frame(PAT_IMPULSE, 16'sd2000, 1'b0);
		expect_drop = 1'b0;
		wait_for_sop();
		wait_for_idle();
		repeat (20) step();
		// Engine still sound after the overflow
		run_frame(PAT_ALT, 16'sd480);
		repeat (5) step();
		if (frames_out != GOOD_FRAMES)
			abort_run($sformatf("Error at %0t: frames_out got %0d expected %0d", $time,
				frames_out, GOOD_FRAMES));
		else
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

// ==== src.f ====
dft_cfg_pkg.sv
dft_stream_pkg.sv
dft_sample_mem.sv
dft_addr_gen.sv
dft_butterfly.sv
dft_unload.sv
dft_mem_top.sv
tb_dft_mem_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the DFT engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dft_mem_top \
	-f src.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0
